/* design/mem_cfg.svh */
// Width constants for the memory access unit, included by the package and every RTL file.
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Data width of the core and the bus.
`define MEM_XLEN 32

// Bytes in one data word.
`define MEM_BYTES (`MEM_XLEN / 8)

// Wishbone word address, the byte offset bits are not on the bus.
`define MEM_ADR_W 30

// One Wishbone select line per byte lane.
`define MEM_SEL_W `MEM_BYTES

`endif

/* design/mem_pkg.sv */
// Shared request, response, opcode and Wishbone types, imported by every module of the unit.
`default_nettype none
`include "mem_cfg.svh"

package mem_pkg;

    // Kind of memory request.
    typedef enum logic [2:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_LR,
        MEM_SC,
        MEM_AMO
    } mem_op_t;

    // Function of a read-modify-write atomic.
    typedef enum logic [3:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_OR,
        AMO_AND,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_fn_t;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } access_size_t;

    // RISC-V exception codes.
    typedef enum logic [3:0] {
        CAUSE_NONE           = 4'd0,
        CAUSE_LOAD_MISALIGN  = 4'd4,
        CAUSE_STORE_MISALIGN = 4'd6
    } trap_cause_t;

    typedef struct packed {
        mem_op_t             op;
        amo_fn_t             fn;
        access_size_t        size;
        logic                is_unsigned;
        logic [`MEM_XLEN-1:0] addr;
        logic [`MEM_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_XLEN-1:0] rd_val;
        logic                trap;
        trap_cause_t         cause;
    } mem_rsp_t;

    // Wishbone classic, master to slave.
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`MEM_ADR_W-1:0] adr;
        logic [`MEM_SEL_W-1:0] sel;
        logic [`MEM_XLEN-1:0]  dat;
    } wb_m2s_t;

    // Wishbone classic, slave to master.
    typedef struct packed {
        logic                ack;
        logic [`MEM_XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

/* design/amo_alu.sv */
// Combinational write-back value for atomics, fed with the old memory word and the operand.
`timescale 1ns/10ps
`default_nettype none
`include "mem_cfg.svh"

module amo_alu import mem_pkg::*; (
    input  wire amo_fn_t             fn,
    input  wire logic [`MEM_XLEN-1:0] old_val,
    input  wire logic [`MEM_XLEN-1:0] operand,
    output logic [`MEM_XLEN-1:0]      new_val
);

    logic                 sub_en;
    logic                 sign_flip;
    logic [`MEM_XLEN-1:0] lhs;
    logic [`MEM_XLEN-1:0] rhs;
    logic [`MEM_XLEN:0]   sum;
    logic                 old_ge;

    // Compare functions subtract, signed ones also bias the sign bit.
    always_comb begin
        sub_en    = fn inside {AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
        sign_flip = fn inside {AMO_MIN, AMO_MAX};
    end

    // Shared adder, the carry out is old >= operand when subtracting.
    always_comb begin
        lhs = old_val;
        rhs = sub_en ? ~operand : operand;
        if (sign_flip) begin
            lhs[`MEM_XLEN-1] = ~lhs[`MEM_XLEN-1];
            rhs[`MEM_XLEN-1] = ~rhs[`MEM_XLEN-1];
        end
        sum    = {1'b0, lhs} + {1'b0, rhs} + {{`MEM_XLEN{1'b0}}, sub_en};
        old_ge = sum[`MEM_XLEN];
    end

    always_comb begin
        case (fn)
            AMO_SWAP: new_val = operand;
            AMO_ADD:  new_val = sum[`MEM_XLEN-1:0];
            AMO_XOR:  new_val = old_val ^ operand;
            AMO_OR:   new_val = old_val | operand;
            AMO_AND:  new_val = old_val & operand;
            AMO_MIN,
            AMO_MINU: begin
                new_val = old_ge ? operand : old_val;
            end
            AMO_MAX,
            AMO_MAXU: begin
                new_val = old_ge ? old_val : operand;
            end
            // Unused codes behave as swap.
            default:  new_val = operand;
        endcase
    end

endmodule

`default_nettype wire

/* design/lane_align.sv */
// Byte lane steering for stores and loads on the data bus, with the misalignment check.
`timescale 1ns/10ps
`default_nettype none
`include "mem_cfg.svh"

module lane_align import mem_pkg::*; (
    input  wire access_size_t        size,
    input  wire logic [1:0]          addr_lo,
    input  wire logic                is_unsigned,
    input  wire logic [`MEM_XLEN-1:0] store_data,
    input  wire logic [`MEM_XLEN-1:0] bus_rdata,
    output logic [`MEM_SEL_W-1:0]     sel,
    output logic [`MEM_XLEN-1:0]      lane_wdata,
    output logic [`MEM_XLEN-1:0]      load_val,
    output logic                     misaligned
);

    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic        byte_ext;
    logic        half_ext;

    // Addressed lanes of the read word.
    always_comb begin
        byte_val = bus_rdata[{addr_lo, 3'b000} +: 8];
        half_val = addr_lo[1] ? bus_rdata[31:16] : bus_rdata[15:0];
        byte_ext = !is_unsigned && byte_val[7];
        half_ext = !is_unsigned && half_val[15];
    end

    // Store side.
    always_comb begin
        case (size)
            SIZE_B: begin
                sel        = {{(`MEM_SEL_W-1){1'b0}}, 1'b1} << addr_lo;
                lane_wdata = {`MEM_BYTES{store_data[7:0]}};
                misaligned = 1'b0;
            end
            SIZE_H: begin
                sel        = addr_lo[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {(`MEM_BYTES / 2){store_data[15:0]}};
                misaligned = addr_lo[0];
            end
            // Word, and the unused size code.
            default: begin
                sel        = {`MEM_SEL_W{1'b1}};
                lane_wdata = store_data;
                misaligned = addr_lo != 2'b00;
            end
        endcase
    end

    // Load side.
    always_comb begin
        case (size)
            SIZE_B:  load_val = {{(`MEM_XLEN-8){byte_ext}}, byte_val};
            SIZE_H:  load_val = {{(`MEM_XLEN-16){half_ext}}, half_val};
            default: load_val = bus_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* design/mem_access_ctrl.sv */
// Request FSM of the memory unit: holds the LR/SC reservation and runs the Wishbone cycles.
`timescale 1ns/10ps
`default_nettype none
`include "mem_cfg.svh"

module mem_access_ctrl import mem_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_valid,
    input  wire mem_req_t             req,
    output logic                      req_ready,
    input  wire logic [`MEM_SEL_W-1:0] sel,
    input  wire logic [`MEM_XLEN-1:0]  lane_wdata,
    input  wire logic [`MEM_XLEN-1:0]  load_val,
    input  wire logic                 misaligned,
    input  wire logic [`MEM_XLEN-1:0]  amo_new,
    output mem_req_t                  cur_req,
    output wb_m2s_t                   wb_o,
    input  wire wb_s2m_t              wb_i,
    output logic                      rsp_valid,
    output mem_rsp_t                  rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SINGLE,
        ST_AMO_READ,
        ST_AMO_WRITE,
        ST_RESPOND
    } ctrl_state_t;

    ctrl_state_t           state;
    logic                  resv_valid;
    logic [`MEM_ADR_W-1:0] resv_addr;
    logic                  sc_hit;
    logic [`MEM_XLEN-1:0]  rd_hold;
    logic [`MEM_XLEN-1:0]  amo_hold;

    logic                  issue;
    logic                  sc_fail;
    logic                  fault;
    logic                  early_rsp;
    logic                  bus_active;
    logic                  single_ack;
    logic                  read_ack;
    logic                  is_write_op;
    trap_cause_t           cause;
    logic [`MEM_ADR_W-1:0] req_word;
    logic [`MEM_ADR_W-1:0] cur_word;

    assign req_ready = state == ST_IDLE;

    always_comb begin
        req_word    = req.addr[`MEM_XLEN-1 -: `MEM_ADR_W];
        cur_word    = cur_req.addr[`MEM_XLEN-1 -: `MEM_ADR_W];
        issue       = (state == ST_SINGLE) || (state == ST_AMO_READ);
        sc_fail     = (cur_req.op == MEM_SC) && !sc_hit;
        // Faults are resolved in the first cycle, before any bus cycle starts.
        fault       = misaligned || sc_fail;
        early_rsp   = issue && fault;
        bus_active  = (issue && !fault) || (state == ST_AMO_WRITE);
        single_ack  = (state == ST_SINGLE) && !fault && wb_i.ack;
        read_ack    = (state == ST_AMO_READ) && !fault && wb_i.ack;
        is_write_op = cur_req.op inside {MEM_STORE, MEM_SC, MEM_AMO};
        cause       = is_write_op ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN;
    end

    // Bus outputs follow the state and the stored request.
    always_comb begin
        wb_o.cyc = bus_active;
        wb_o.stb = bus_active;
        wb_o.we  = (state == ST_AMO_WRITE) ||
                   ((state == ST_SINGLE) && (cur_req.op inside {MEM_STORE, MEM_SC}));
        wb_o.adr = cur_word;
        wb_o.sel = sel;
        wb_o.dat = (state == ST_AMO_WRITE) ? amo_hold : lane_wdata;
    end

    // A failed SC answers 1, a trap answers 0.
    always_comb begin
        rsp_valid  = early_rsp || (state == ST_RESPOND);
        rsp.trap   = early_rsp && misaligned;
        rsp.cause  = (early_rsp && misaligned) ? cause : CAUSE_NONE;
        if (state == ST_RESPOND) begin
            rsp.rd_val = rd_hold;
        end else begin
            rsp.rd_val = {{(`MEM_XLEN-1){1'b0}}, sc_fail && !misaligned};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            resv_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= (req.op == MEM_AMO) ? ST_AMO_READ : ST_SINGLE;
                        if (req.op != MEM_LR) begin
                            resv_valid <= 1'b0;
                        end
                    end
                end
                ST_SINGLE: begin
                    if (fault) begin
                        state <= ST_IDLE;
                    end else if (wb_i.ack) begin
                        state <= ST_RESPOND;
                        if (cur_req.op == MEM_LR) begin
                            resv_valid <= 1'b1;
                        end
                    end
                end
                ST_AMO_READ: begin
                    if (fault) begin
                        state <= ST_IDLE;
                    end else if (wb_i.ack) begin
                        state <= ST_AMO_WRITE;
                    end
                end
                ST_AMO_WRITE: begin
                    if (wb_i.ack) begin
                        state <= ST_RESPOND;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request, reservation address and response data.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_req <= req;
            // Atomics always move a full word.
            if (req.op inside {MEM_LR, MEM_SC, MEM_AMO}) begin
                cur_req.size <= SIZE_W;
            end
            sc_hit <= resv_valid && (req_word == resv_addr);
        end
        if (single_ack) begin
            if (cur_req.op inside {MEM_LOAD, MEM_LR}) begin
                rd_hold <= load_val;
            end else begin
                rd_hold <= '0;
            end
            if (cur_req.op == MEM_LR) begin
                resv_addr <= cur_word;
            end
        end
        if (read_ack) begin
            rd_hold  <= load_val;
            amo_hold <= amo_new;
        end
    end

endmodule

`default_nettype wire

/* design/mem_stage.sv */
// Top level of the memory access unit, between the request/response ports and the data bus.
`timescale 1ns/10ps
`default_nettype none
`include "mem_cfg.svh"

module mem_stage import mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req_valid,
    input  wire mem_req_t req,
    output logic          req_ready,
    output logic          rsp_valid,
    output mem_rsp_t      rsp,
    output wb_m2s_t       wb_o,
    input  wire wb_s2m_t  wb_i
);

    mem_req_t              cur_req;
    logic [`MEM_SEL_W-1:0] sel;
    logic [`MEM_XLEN-1:0]  lane_wdata;
    logic [`MEM_XLEN-1:0]  load_val;
    logic                  misaligned;
    logic [`MEM_XLEN-1:0]  amo_new;

    mem_access_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .sel        (sel),
        .lane_wdata (lane_wdata),
        .load_val   (load_val),
        .misaligned (misaligned),
        .amo_new    (amo_new),
        .cur_req    (cur_req),
        .wb_o       (wb_o),
        .wb_i       (wb_i),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    // Lanes are taken from the stored request and the raw bus data.
    lane_align u_lane_align (
        .size        (cur_req.size),
        .addr_lo     (cur_req.addr[1:0]),
        .is_unsigned (cur_req.is_unsigned),
        .store_data  (cur_req.wdata),
        .bus_rdata   (wb_i.dat),
        .sel         (sel),
        .lane_wdata  (lane_wdata),
        .load_val    (load_val),
        .misaligned  (misaligned)
    );

    amo_alu u_amo_alu (
        .fn      (cur_req.fn),
        .old_val (wb_i.dat),
        .operand (cur_req.wdata),
        .new_val (amo_new)
    );

endmodule

`default_nettype wire

/* tests/tb_mem_model.svh */
// Wishbone memory with random wait states and the reference model, included by the testbench top.
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

localparam int MEM_WORDS = 16;

// Memory behind the bus, and the model's copy of it.
logic [31:0] bus_mem [MEM_WORDS];
logic [31:0] ref_mem [MEM_WORDS];
logic        ref_resv_valid;
logic [3:0]  ref_resv_word;
logic        wb_ack = 1'b0;
logic [31:0] wb_rdat = 32'd0;
logic        slave_busy = 1'b0;
int          wait_left = 0;
integer      slave_seed;

task automatic model_init();
    int i;
    // Wait states draw from their own stream.
    slave_seed     = seed + 1;
    ref_resv_valid = 1'b0;
    ref_resv_word  = 4'd0;
    for (i = 0; i < MEM_WORDS; i++) begin
        bus_mem[i] = (i + 1) * 32'h9e37_79b9;
        ref_mem[i] = bus_mem[i];
    end
endtask

// LR, SC and atomics always move a whole word.
function automatic access_size_t eff_size(input mem_req_t r);
    if (r.op inside {MEM_LR, MEM_SC, MEM_AMO}) begin
        return SIZE_W;
    end else begin
        return r.size;
    end
endfunction

function automatic logic [31:0] amo_result(input amo_fn_t fn, input logic [31:0] a,
                                           input logic [31:0] b);
    case (fn)
        AMO_SWAP: return b;
        AMO_ADD:  return a + b;
        AMO_XOR:  return a ^ b;
        AMO_OR:   return a | b;
        AMO_AND:  return a & b;
        AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
        AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
        AMO_MINU: return (a < b) ? a : b;
        AMO_MAXU: return (a > b) ? a : b;
        default:  return b;
    endcase
endfunction

// Expected response of one request; fault means no bus cycle is allowed.
task automatic model_exec(input mem_req_t r, output mem_rsp_t exp, output logic fault);
    logic [1:0]  off;
    logic [3:0]  word;
    logic [31:0] shifted;
    logic        sc_ok;
    int          nbytes;
    int          b;
    off     = r.addr[1:0];
    word    = r.addr[5:2];
    nbytes  = (eff_size(r) == SIZE_B) ? 1 : (eff_size(r) == SIZE_H) ? 2 : 4;
    sc_ok   = (r.op == MEM_SC) && ref_resv_valid && (ref_resv_word == word);
    shifted = ref_mem[word] >> (8 * off);
    exp     = '0;
    fault   = 1'b1;
    if (r.op != MEM_LR) begin
        ref_resv_valid = 1'b0;
    end
    if ((off % nbytes) != 0) begin
        exp.trap  = 1'b1;
        exp.cause = (r.op inside {MEM_LOAD, MEM_LR}) ? CAUSE_LOAD_MISALIGN
                                                     : CAUSE_STORE_MISALIGN;
    end else if ((r.op == MEM_SC) && !sc_ok) begin
        exp.rd_val = 32'd1;
    end else begin
        fault = 1'b0;
        case (r.op)
            MEM_LOAD, MEM_LR: begin
                if (nbytes == 1) begin
                    exp.rd_val = r.is_unsigned ? {24'd0, shifted[7:0]}
                                               : {{24{shifted[7]}}, shifted[7:0]};
                end else if (nbytes == 2) begin
                    exp.rd_val = r.is_unsigned ? {16'd0, shifted[15:0]}
                                               : {{16{shifted[15]}}, shifted[15:0]};
                end else begin
                    exp.rd_val = shifted;
                end
                if (r.op == MEM_LR) begin
                    ref_resv_valid = 1'b1;
                    ref_resv_word  = word;
                end
            end
            MEM_AMO: begin
                exp.rd_val    = ref_mem[word];
                ref_mem[word] = amo_result(r.fn, ref_mem[word], r.wdata);
            end
            default: begin
                for (b = 0; b < 4; b++) begin
                    if (b >= off && b < off + nbytes) begin
                        ref_mem[word][8*b +: 8] = r.wdata[8*(b-off) +: 8];
                    end
                end
            end
        endcase
    end
endtask

// One falling edge of the bus slave; ack lasts a single cycle.
task automatic slave_step();
    int b;
    wb_ack = 1'b0;
    if (wb_o.cyc && wb_o.stb) begin
        if (!slave_busy) begin
            wait_left  = $random(slave_seed) & 3;
            slave_busy = 1'b1;
        end
        if (wait_left == 0) begin
            slave_busy = 1'b0;
            wb_ack     = 1'b1;
            if (wb_o.we) begin
                for (b = 0; b < 4; b++) begin
                    if (wb_o.sel[b]) begin
                        bus_mem[wb_o.adr[3:0]][8*b +: 8] = wb_o.dat[8*b +: 8];
                    end
                end
            end else begin
                wb_rdat = bus_mem[wb_o.adr[3:0]];
            end
        end else begin
            wait_left--;
        end
    end
endtask

`endif

/* tests/tb_mem_stage.sv */
// Testbench top for the memory access unit, built from all.f and run by the Makefile.
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage import mem_pkg::*; ();

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 16 + 100;

    logic     clk;
    logic     rst;
    logic     req_valid;
    mem_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    mem_rsp_t rsp;
    wb_m2s_t  wb_o;
    wb_s2m_t  wb_i;

    integer   seed;
    int       cycles = 0;
    int       data_errs = 0;
    int       bus_errs = 0;
    int       proto_errs = 0;
    int       n_issued = 0;
    int       n_rsp = 0;
    wb_m2s_t  held_wb;
    logic     held_valid = 1'b0;

    `include "tb_mem_model.svh"

    assign wb_i = {wb_ack, wb_rdat};

    mem_stage dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .wb_o      (wb_o),
        .wb_i      (wb_i)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Hold check first, then the slave moves.
    always @(negedge clk) begin
        if (!rst) begin
            if (held_valid && !wb_ack) begin
                check_wb(wb_o, held_wb);
            end
            if (rsp_valid) begin
                n_rsp++;
            end
            slave_step();
            held_wb    = wb_o;
            held_valid = wb_o.cyc && wb_o.stb;
        end
    end

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got.rd_val !== exp.rd_val) begin
            $display("MISMATCH rsp.rd_val got %h expected %h at request %0d",
                     got.rd_val, exp.rd_val, n_issued);
            data_errs++;
        end
        if (got.trap !== exp.trap || got.cause !== exp.cause) begin
            $display("MISMATCH rsp.trap/cause got %h/%h expected %h/%h at request %0d",
                     got.trap, got.cause, exp.trap, exp.cause, n_issued);
            data_errs++;
        end
    endtask

    task automatic check_word(input int idx, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH mem[%0d] got %h expected %h", idx, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_wb(input wb_m2s_t got, input wb_m2s_t exp);
        if (got !== exp) begin
            $display("MISMATCH wb_o got %h expected %h during a wait state", got, exp);
            bus_errs++;
        end
    endtask

    task automatic make_req(input mem_op_t op, input logic [3:0] word, input logic misalign,
                            output mem_req_t r);
        logic [31:0] a;
        logic [3:0]  f;
        logic [1:0]  off;
        a = $random(seed);
        f = 4'(a[31:8] % 9);
        r = '0;
        r.op          = op;
        r.fn          = amo_fn_t'(f);
        r.size        = access_size_t'(2'(a[5:4] % 3));
        r.is_unsigned = a[6];
        r.wdata       = $random(seed);
        // A byte access can only go misaligned once widened.
        if (misalign && eff_size(r) == SIZE_B) begin
            r.size = SIZE_H;
        end
        case (eff_size(r))
            SIZE_B:  off = a[1:0];
            SIZE_H:  off = {a[1], misalign};
            default: off = misalign ? ((a[1:0] == 2'b00) ? 2'b10 : a[1:0]) : 2'b00;
        endcase
        r.addr = {26'd0, word, off};
    endtask

    task automatic issue(input mem_req_t r);
        mem_rsp_t exp;
        logic     exp_fault;
        logic     saw_cyc;
        int       lat;
        model_exec(r, exp, exp_fault);
        while (!req_ready) begin
            @(negedge clk);
        end
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
        lat       = 1;
        saw_cyc   = wb_o.cyc;
        while (!rsp_valid) begin
            if (req_ready) begin
                $display("req_ready went high before the response of request %0d.", n_issued);
                proto_errs++;
            end
            @(negedge clk);
            lat++;
            saw_cyc = saw_cyc | wb_o.cyc;
        end
        check_rsp(rsp, exp);
        if (exp_fault && (lat != 1 || saw_cyc)) begin
            $display("Request %0d did not answer 1 cycle after acceptance without a bus cycle.",
                     n_issued);
            proto_errs++;
        end else if (!exp_fault && !saw_cyc) begin
            $display("Request %0d answered without any bus cycle.", n_issued);
            proto_errs++;
        end
        n_issued++;
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] aux;
        logic [3:0]  word;
        mem_req_t    r;
        int          i;
        seed      = 32'h794f294a;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        model_init();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!req_ready || wb_o.cyc || wb_o.stb || wb_o.we || rsp_valid) begin
            $display("After reset req_ready should be high and cyc, stb, we, rsp_valid low.");
            proto_errs++;
        end
        while (n_issued < NUM_REQ) begin
            pick = $random(seed);
            aux  = $random(seed);
            pick = pick % 100;
            word = aux[3:0];
            if (pick < 40) begin
                make_req(aux[4] ? MEM_STORE : MEM_LOAD, word, 1'b0, r);
                issue(r);
            end else if (pick < 60) begin
                make_req(MEM_AMO, word, 1'b0, r);
                issue(r);
            end else if (pick < 90) begin
                make_req(MEM_LR, word, 1'b0, r);
                issue(r);
                // A load in between kills the reservation.
                if (aux[6:5] == 2'b00) begin
                    make_req(MEM_LOAD, aux[11:8], 1'b0, r);
                    issue(r);
                end
                make_req(MEM_SC, aux[7] ? aux[11:8] : word, 1'b0, r);
                issue(r);
            end else begin
                make_req(mem_op_t'(3'(aux[15:12] % 5)), word, 1'b1, r);
                issue(r);
            end
        end
        repeat (2) @(negedge clk);
        for (i = 0; i < MEM_WORDS; i++) begin
            check_word(i, bus_mem[i], ref_mem[i]);
        end
        if (n_rsp != n_issued) begin
            $display("Saw %0d responses for %0d accepted requests.", n_rsp, n_issued);
            proto_errs++;
        end
        $display("Errors: %0d data, %0d bus hold, %0d handshake, over %0d requests",
                 data_errs, bus_errs, proto_errs, n_issued);
        if (data_errs + bus_errs + proto_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
+incdir+tests
design/mem_pkg.sv
design/amo_alu.sv
design/lane_align.sv
design/mem_access_ctrl.sv
design/mem_stage.sv
tests/tb_mem_stage.sv

/* Makefile */
# Verilator simulation of the memory access unit.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mem_stage -Mdir obj_dir
	./obj_dir/Vtb_mem_stage | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)." && exit 1)

clean:
	rm -rf obj_dir $(LOG)
